//--- Makefile
TOP       ?= ex_stage_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "TB PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/ex_stage_tb.sv
`timescale 1ns/10ps

module ex_stage_tb
    import ex_pkg::*;
();

    localparam int          CLK_PERIOD    = 40;
    localparam int          RESET_CYCLES  = 16;
    localparam int          READY_TIMEOUT = 8;
    localparam logic [31:0] SEED          = 32'h5c59_eee1;

    // Worst case per instruction sent, including same-index stalls
    localparam int SEND_CYCLES = 6;
    localparam int SEND_COUNT  = 14 * 3 + 8 * 4 + 4;
    localparam int TEST_CYCLES = RESET_CYCLES + SEND_COUNT * SEND_CYCLES + 40;
    localparam int WATCHDOG_NS = TEST_CYCLES * 2 * CLK_PERIOD;

    logic        clk;
    logic        rst;
    ex_issue_t   issue_i;
    logic        advance_i;
    logic        flush_i;
    logic        clear_i;
    logic        dcache_ready_i;
    logic        advance_ready_o;
    dcache_req_t dcache_req_o;
    ex_mem_t     ex_mem_o;
    ex_fwd_t     fwd_o;
    int          mismatches;
    int          failures;

    ex_stage dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("ERROR: watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
        $display("TB FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////
    // Reference rules
    ////////////////////////////////////////////////////////////

    function automatic logic [31:0] int_model(ex_issue_t t);
        logic [31:0] a;
        logic [31:0] b;
        a = t.oprand1;
        b = t.oprand2;
        case (t.op)
            OP_ADD:   return a + b;
            OP_SUB:   return a - b;
            OP_SLT:   return {31'b0, $signed(a) < $signed(b)};
            OP_SLTU:  return {31'b0, a < b};
            OP_AND:   return a & b;
            OP_OR:    return a | b;
            OP_XOR:   return a ^ b;
            OP_NOR:   return ~(a | b);
            OP_SLL:   return a << b[4:0];
            OP_SRL:   return a >> b[4:0];
            OP_SRA:   return $signed(a) >>> b[4:0];
            OP_LUI:   return b;
            OP_PCADD: return t.pc + b;
            OP_JUMP:  return t.pc + 32'd4;
            default:  return 32'h0;
        endcase
    endfunction

    function automatic ex_size_e access_size(ex_op_e op);
        case (op)
            OP_LD_B, OP_LD_BU, OP_ST_B: return SZ_BYTE;
            OP_LD_H, OP_LD_HU, OP_ST_H: return SZ_HALF;
            default:                    return SZ_WORD;
        endcase
    endfunction

    function automatic logic [3:0] lane_select(ex_size_e size, logic [1:0] off);
        case (size)
            SZ_BYTE: return 4'b0001 << off;
            SZ_HALF: return 4'b0011 << off;
            default: return 4'b1111;
        endcase
    endfunction

    function automatic logic [31:0] store_lanes(ex_op_e op, logic [31:0] b, logic [1:0] off);
        case (op)
            OP_ST_B: return {24'b0, b[7:0]} << (8 * off);
            OP_ST_H: return {16'b0, b[15:0]} << (8 * off);
            OP_ST_W: return b;
            default: return 32'h0;
        endcase
    endfunction

    function automatic logic is_misaligned(ex_size_e size, logic [1:0] off);
        return (size == SZ_HALF && off[0]) || (size == SZ_WORD && off != 2'b00);
    endfunction

    function automatic ex_issue_t make_instr(ex_op_e op, logic [31:0] a, logic [31:0] b,
                                             logic [31:0] imm);
        ex_issue_t t;
        t.valid   = 1'b1;
        t.op      = op;
        t.pc      = $urandom & 32'hffff_fffc;
        t.oprand1 = a;
        t.oprand2 = b;
        t.imm     = imm;
        t.waddr   = 5'($urandom_range(31, 1));
        t.wreg    = 1'b1;
        return t;
    endfunction

    task automatic report_mismatch(string name, logic [127:0] exp, logic [127:0] act);
        mismatches++;
        $display("CHECK FAILED at %0t ns: %s expected %0h, got %0h", $time, name, exp, act);
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    // Waits for ready, advances once, returns request, forward and buffer
    task automatic send_instr(input ex_issue_t instr, output dcache_req_t req,
                              output ex_fwd_t fwd, output ex_mem_t mem);
        int waited;
        waited = 0;
        req    = '0;
        fwd    = '0;
        @(posedge clk);
        issue_i   <= instr;
        advance_i <= 1'b0;
        @(negedge clk);
        while (!advance_ready_o && waited < READY_TIMEOUT) begin
            @(negedge clk);
            waited++;
        end
        if (!advance_ready_o) begin
            failures++;
            $display("ERROR at %0t ns: advance_ready_o stayed low for %0d cycles", $time, waited);
        end else begin
            @(posedge clk);
            advance_i <= 1'b1;
            @(negedge clk);
            req = dcache_req_o;
            fwd = fwd_o;
            @(posedge clk);
            advance_i <= 1'b0;
            issue_i   <= '0;
            @(negedge clk);
        end
        mem = ex_mem_o;
    endtask

    task automatic int_ops_test();
        ex_op_e      ops [14] = '{OP_ADD, OP_SUB, OP_SLT, OP_SLTU, OP_AND, OP_OR, OP_XOR,
                                  OP_NOR, OP_SLL, OP_SRL, OP_SRA, OP_LUI, OP_PCADD, OP_JUMP};
        ex_issue_t   instr;
        dcache_req_t req;
        ex_fwd_t     fwd;
        ex_mem_t     mem;
        logic [31:0] exp;
        foreach (ops[i]) begin
            for (int r = 0; r < 3; r++) begin
                // First pass straddles the sign boundary
                if (r == 0) begin
                    instr = make_instr(ops[i], 32'h8000_0000, 32'h7fff_fff3, 32'h0);
                end else begin
                    instr = make_instr(ops[i], $urandom, $urandom, $urandom);
                end
                exp = int_model(instr);
                send_instr(instr, req, fwd, mem);
                if (mem.wdata !== exp)
                    report_mismatch("ex_mem_o.wdata", 128'(exp), 128'(mem.wdata));
                if (mem.valid !== 1'b1)
                    report_mismatch("ex_mem_o.valid", 128'(1), 128'(mem.valid));
                if (mem.pc !== instr.pc)
                    report_mismatch("ex_mem_o.pc", 128'(instr.pc), 128'(mem.pc));
                if (mem.waddr !== instr.waddr)
                    report_mismatch("ex_mem_o.waddr", 128'(instr.waddr), 128'(mem.waddr));
                if (mem.wreg !== 1'b1)
                    report_mismatch("ex_mem_o.wreg", 128'(1), 128'(mem.wreg));
                if (fwd.wdata !== exp)
                    report_mismatch("fwd_o.wdata", 128'(exp), 128'(fwd.wdata));
                if (fwd.data_valid !== 1'b1)
                    report_mismatch("fwd_o.data_valid", 128'(1), 128'(fwd.data_valid));
                if (fwd.wreg !== 1'b1)
                    report_mismatch("fwd_o.wreg", 128'(1), 128'(fwd.wreg));
                if (fwd.waddr !== instr.waddr)
                    report_mismatch("fwd_o.waddr", 128'(instr.waddr), 128'(fwd.waddr));
                if (req.ce !== 1'b0)
                    report_mismatch("dcache_req_o.ce", 128'(0), 128'(req.ce));
            end
        end
    endtask

    task automatic load_store_test();
        ex_op_e      ops [8] = '{OP_LD_B, OP_LD_BU, OP_LD_H, OP_LD_HU, OP_LD_W,
                                 OP_ST_B, OP_ST_H, OP_ST_W};
        ex_issue_t   instr;
        dcache_req_t req;
        ex_fwd_t     fwd;
        ex_mem_t     mem;
        ex_size_e    size;
        logic [31:0] base;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  sel;
        logic        store;
        foreach (ops[i]) begin
            for (int off = 0; off < 4; off++) begin
                base  = $urandom;
                instr = make_instr(ops[i], {base[31:2], 2'(off)}, $urandom,
                                   $urandom & 32'hffff_fffc);
                addr  = instr.oprand1 + instr.imm;
                size  = access_size(ops[i]);
                sel   = lane_select(size, addr[1:0]);
                data  = store_lanes(ops[i], instr.oprand2, addr[1:0]);
                store = ops[i] inside {OP_ST_B, OP_ST_H, OP_ST_W};
                send_instr(instr, req, fwd, mem);
                if (req.ce !== 1'b1)
                    report_mismatch("dcache_req_o.ce", 128'(1), 128'(req.ce));
                if (req.we !== store)
                    report_mismatch("dcache_req_o.we", 128'(store), 128'(req.we));
                if (req.size !== size)
                    report_mismatch("dcache_req_o.size", 128'(size), 128'(req.size));
                if (req.sel !== sel)
                    report_mismatch("dcache_req_o.sel", 128'(sel), 128'(req.sel));
                if (req.addr !== addr)
                    report_mismatch("dcache_req_o.addr", 128'(addr), 128'(req.addr));
                if (req.data !== data)
                    report_mismatch("dcache_req_o.data", 128'(data), 128'(req.data));
                if (fwd.data_valid !== store)
                    report_mismatch("fwd_o.data_valid", 128'(store), 128'(fwd.data_valid));
                if (mem.excp_ale !== is_misaligned(size, addr[1:0]))
                    report_mismatch("ex_mem_o.excp_ale", 128'(is_misaligned(size, addr[1:0])),
                                    128'(mem.excp_ale));
                if (mem.mem_addr !== addr)
                    report_mismatch("ex_mem_o.mem_addr", 128'(addr), 128'(mem.mem_addr));
            end
        end
    endtask

    task automatic backpressure_test();
        ex_issue_t   fill;
        ex_issue_t   ld;
        dcache_req_t req;
        ex_fwd_t     fwd;
        ex_mem_t     held;
        ex_mem_t     mem;
        fill = make_instr(OP_ADD, $urandom, $urandom, 32'h0);
        ld   = make_instr(OP_LD_W, $urandom & 32'hffff_fffc, $urandom, 32'h0);
        send_instr(fill, req, fwd, held);
        @(posedge clk);
        dcache_ready_i <= 1'b0;
        issue_i        <= ld;
        repeat (4) begin
            @(negedge clk);
            if (advance_ready_o !== 1'b0)
                report_mismatch("advance_ready_o", 128'(0), 128'(advance_ready_o));
            if (dcache_req_o.ce !== 1'b0)
                report_mismatch("dcache_req_o.ce", 128'(0), 128'(dcache_req_o.ce));
            if (ex_mem_o !== held) report_mismatch("ex_mem_o", 128'(held), 128'(ex_mem_o));
        end
        @(posedge clk);
        dcache_ready_i <= 1'b1;
        send_instr(ld, req, fwd, mem);
        if (req.ce !== 1'b1) report_mismatch("dcache_req_o.ce", 128'(1), 128'(req.ce));
        if (mem.op !== OP_LD_W) report_mismatch("ex_mem_o.op", 128'(OP_LD_W), 128'(mem.op));
    endtask

    task automatic index_hazard_test();
        ex_issue_t   first;
        ex_issue_t   second;
        ex_issue_t   other;
        logic [31:0] base;
        base   = $urandom & 32'hffff_fff0;
        first  = make_instr(OP_LD_W, base, $urandom, 32'h0);
        second = make_instr(OP_ST_W, base + 32'd4, $urandom, 32'h0);
        other  = make_instr(OP_LD_W, base + 32'd16, $urandom, 32'h0);
        // Idle edges empty the index history
        repeat (3) @(posedge clk);
        issue_i   <= first;
        advance_i <= 1'b1;
        @(negedge clk);
        if (dcache_req_o.ce !== 1'b1)
            report_mismatch("dcache_req_o.ce", 128'(1), 128'(dcache_req_o.ce));
        @(posedge clk);
        issue_i   <= second;
        advance_i <= 1'b0;
        for (int n = 0; n < 2; n++) begin
            @(negedge clk);
            if (advance_ready_o !== 1'b0)
                report_mismatch("advance_ready_o", 128'(0), 128'(advance_ready_o));
            @(posedge clk);
        end
        @(negedge clk);
        if (advance_ready_o !== 1'b1)
            report_mismatch("advance_ready_o", 128'(1), 128'(advance_ready_o));
        @(posedge clk);
        advance_i <= 1'b1;
        @(negedge clk);
        if (dcache_req_o.addr !== base + 32'd4)
            report_mismatch("dcache_req_o.addr", 128'(base + 32'd4), 128'(dcache_req_o.addr));
        @(posedge clk);
        issue_i   <= other;
        advance_i <= 1'b0;
        // Next index over does not stall
        @(negedge clk);
        if (advance_ready_o !== 1'b1)
            report_mismatch("advance_ready_o", 128'(1), 128'(advance_ready_o));
        @(posedge clk);
        issue_i <= '0;
    endtask

    task automatic flush_clear_test();
        ex_issue_t   fill;
        ex_issue_t   ld;
        dcache_req_t req;
        ex_fwd_t     fwd;
        ex_mem_t     mem;
        fill = make_instr(OP_OR, $urandom, $urandom, 32'h0);
        ld   = make_instr(OP_LD_W, $urandom & 32'hffff_fffc, $urandom, 32'h0);
        send_instr(fill, req, fwd, mem);
        repeat (3) @(posedge clk);
        issue_i <= ld;
        @(negedge clk);
        if (advance_ready_o !== 1'b1)
            report_mismatch("advance_ready_o", 128'(1), 128'(advance_ready_o));
        @(posedge clk);
        advance_i <= 1'b1;
        flush_i   <= 1'b1;
        @(negedge clk);
        if (dcache_req_o.ce !== 1'b0)
            report_mismatch("dcache_req_o.ce", 128'(0), 128'(dcache_req_o.ce));
        @(posedge clk);
        advance_i <= 1'b0;
        flush_i   <= 1'b0;
        @(negedge clk);
        if (ex_mem_o !== '0) report_mismatch("ex_mem_o", 128'(0), 128'(ex_mem_o));
        // Flushed access must not block the same index
        if (advance_ready_o !== 1'b1)
            report_mismatch("advance_ready_o", 128'(1), 128'(advance_ready_o));
        send_instr(fill, req, fwd, mem);
        @(posedge clk);
        issue_i   <= fill;
        advance_i <= 1'b1;
        clear_i   <= 1'b1;
        @(posedge clk);
        issue_i   <= '0;
        advance_i <= 1'b0;
        clear_i   <= 1'b0;
        @(negedge clk);
        if (ex_mem_o !== '0) report_mismatch("ex_mem_o", 128'(0), 128'(ex_mem_o));
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(SEED));
        rst            = 1'b1;
        issue_i        = '0;
        advance_i      = 1'b0;
        flush_i        = 1'b0;
        clear_i        = 1'b0;
        dcache_ready_i = 1'b1;
        mismatches     = 0;
        failures       = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        if (advance_ready_o !== 1'b1)
            report_mismatch("advance_ready_o", 128'(1), 128'(advance_ready_o));
        if (dcache_req_o.ce !== 1'b0)
            report_mismatch("dcache_req_o.ce", 128'(0), 128'(dcache_req_o.ce));
        if (ex_mem_o !== '0) report_mismatch("ex_mem_o", 128'(0), 128'(ex_mem_o));
        int_ops_test();
        load_store_test();
        backpressure_test();
        index_hazard_test();
        flush_clear_test();
        repeat (2) @(posedge clk);
        $display("Errors: %0d check failures, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+verilog
verilog/ex_pkg.sv
verilog/ex_int_unit.sv
verilog/ex_mem_req.sv
verilog/ex_result_stage.sv
verilog/ex_stage.sv
bench/ex_stage_tb.sv

//--- verilog/ex_int_unit.sv
`timescale 1ns/10ps
`include "ex_settings.svh"

module ex_int_unit
    import ex_pkg::*;
(
    input  ex_issue_t             issue_i,
    output logic [`EX_DATA_W-1:0] int_result_o
);

    logic [`EX_DATA_W-1:0] op1;
    logic [`EX_DATA_W-1:0] op2;
    logic [`EX_DATA_W-1:0] pc;
    logic [`EX_DATA_W-1:0] diff;
    logic [4:0]            shamt;
    logic                  op1_neg;
    logic                  op2_neg;
    logic                  lt_signed;
    logic                  lt_unsigned;

    assign op1   = issue_i.oprand1;
    assign op2   = issue_i.oprand2;
    assign pc    = issue_i.pc;
    assign shamt = op2[4:0];

    ////////////////////////////////////////////////////////////
    // Compare
    ////////////////////////////////////////////////////////////

    // Two's complement difference, shared with SUB
    assign diff    = op1 + (~op2 + `EX_DATA_W'(1));
    assign op1_neg = op1[`EX_DATA_W-1];
    assign op2_neg = op2[`EX_DATA_W-1];

    // Different signs decide directly, equal signs look at the difference
    assign lt_signed = (op1_neg & ~op2_neg) |
                       (~(op1_neg ^ op2_neg) & diff[`EX_DATA_W-1]);

    assign lt_unsigned = op1 < op2;

    ////////////////////////////////////////////////////////////
    // Result select
    ////////////////////////////////////////////////////////////

    always_comb begin
        case (issue_i.op)
            OP_ADD: begin
                int_result_o = op1 + op2;
            end
            OP_SUB: begin
                int_result_o = diff;
            end
            OP_SLT: begin
                int_result_o = `EX_DATA_W'(lt_signed);
            end
            OP_SLTU: begin
                int_result_o = `EX_DATA_W'(lt_unsigned);
            end
            OP_AND: begin
                int_result_o = op1 & op2;
            end
            OP_OR: begin
                int_result_o = op1 | op2;
            end
            OP_XOR: begin
                int_result_o = op1 ^ op2;
            end
            OP_NOR: begin
                int_result_o = ~(op1 | op2);
            end
            OP_SLL: begin
                int_result_o = op1 << shamt;
            end
            OP_SRL: begin
                int_result_o = op1 >> shamt;
            end
            OP_SRA: begin
                int_result_o = $signed(op1) >>> shamt;
            end
            // Upper immediate already placed by decode
            OP_LUI: begin
                int_result_o = op2;
            end
            OP_PCADD: begin
                int_result_o = pc + op2;
            end
            OP_JUMP: begin
                int_result_o = pc + `EX_DATA_W'(`EX_LINK_OFFSET);
            end
            default: begin
                int_result_o = '0;
            end
        endcase
    end

endmodule

//--- verilog/ex_mem_req.sv
`timescale 1ns/10ps
`include "ex_settings.svh"

module ex_mem_req
    import ex_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  ex_issue_t             issue_i,
    input  logic                  advance_i,
    input  logic                  dcache_ready_i,
    input  logic                  flush_i,
    output logic [`EX_DATA_W-1:0] mem_addr_o,
    output logic                  excp_ale_o,
    output logic                  mem_stall_o,
    output dcache_req_t           dcache_req_o
);

    logic [`EX_DATA_W-1:0]  addr;
    logic [`EX_INDEX_W-1:0] cur_index;
    logic [4:0]             lane_shift;
    logic                   is_load;
    logic                   is_store;
    logic                   access_mem;
    logic                   misaligned;
    logic                   accept;
    logic                   same_index;
    ex_size_e               size;
    mem_hist_t              hist0_q;
    mem_hist_t              hist1_q;

    assign addr       = issue_i.oprand1 + issue_i.imm;
    assign cur_index  = addr[`EX_INDEX_MSB:`EX_INDEX_LSB];
    assign lane_shift = {addr[1:0], 3'b000};

    assign is_load    = op_is_load(issue_i.op);
    assign is_store   = op_is_store(issue_i.op);
    assign access_mem = issue_i.valid & (is_load | is_store);

    always_comb begin
        case (issue_i.op)
            OP_LD_B, OP_LD_BU, OP_ST_B: size = SZ_BYTE;
            OP_LD_H, OP_LD_HU, OP_ST_H: size = SZ_HALF;
            default: size = SZ_WORD;
        endcase
    end

    // Bytes can sit anywhere
    assign misaligned = ((size == SZ_HALF) & addr[0]) |
                        ((size == SZ_WORD) & (addr[1:0] != 2'b00));

    assign mem_addr_o = addr;
    assign excp_ale_o = access_mem & misaligned;

    ////////////////////////////////////////////////////////////
    // Same-index history
    ////////////////////////////////////////////////////////////

    assign accept = access_mem & advance_i & ~flush_i;

    always_ff @(posedge clk) begin
        if (rst) begin
            hist0_q <= '0;
            hist1_q <= '0;
        end else begin
            hist0_q.valid <= accept;
            hist0_q.index <= accept ? cur_index : '0;
            hist1_q       <= hist0_q;
        end
    end

    assign same_index = (hist0_q.valid & (hist0_q.index == cur_index)) |
                        (hist1_q.valid & (hist1_q.index == cur_index));

    assign mem_stall_o = access_mem & (~dcache_ready_i | same_index);

    ////////////////////////////////////////////////////////////
    // Data cache request
    ////////////////////////////////////////////////////////////

    always_comb begin
        dcache_req_o = '0;
        if (accept & dcache_ready_i) begin
            dcache_req_o.ce   = 1'b1;
            dcache_req_o.we   = is_store;
            dcache_req_o.size = size;
            dcache_req_o.addr = addr;
            case (size)
                SZ_BYTE: begin
                    dcache_req_o.sel = `EX_SEL_W'(4'b0001) << addr[1:0];
                    if (is_store) begin
                        dcache_req_o.data = `EX_DATA_W'(issue_i.oprand2[7:0]) << lane_shift;
                    end
                end
                SZ_HALF: begin
                    dcache_req_o.sel = `EX_SEL_W'(4'b0011) << addr[1:0];
                    if (is_store) begin
                        dcache_req_o.data = `EX_DATA_W'(issue_i.oprand2[15:0]) << lane_shift;
                    end
                end
                default: begin
                    dcache_req_o.sel = '1;
                    if (is_store) begin
                        dcache_req_o.data = issue_i.oprand2;
                    end
                end
            endcase
        end
    end

    // Every request comes from an advancing instruction
    assert property (@(posedge clk) disable iff (rst)
        dcache_req_o.ce |-> advance_i);

    // Controller only advances while the stage reports ready
    assert property (@(posedge clk) disable iff (rst)
        dcache_req_o.ce |-> !mem_stall_o);

endmodule

//--- verilog/ex_pkg.sv
`include "ex_settings.svh"

package ex_pkg;

    typedef enum logic [4:0] {
        OP_NOP,
        OP_ADD,
        OP_SUB,
        OP_SLT,
        OP_SLTU,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_NOR,
        OP_SLL,
        OP_SRL,
        OP_SRA,
        OP_LUI,
        OP_PCADD,
        OP_JUMP,
        OP_LD_B,
        OP_LD_BU,
        OP_LD_H,
        OP_LD_HU,
        OP_LD_W,
        OP_ST_B,
        OP_ST_H,
        OP_ST_W
    } ex_op_e;

    // Request type seen by the data cache
    typedef enum logic [1:0] {
        SZ_BYTE = 2'd0,
        SZ_HALF = 2'd1,
        SZ_WORD = 2'd2
    } ex_size_e;

    typedef struct packed {
        logic                      valid;
        ex_op_e                    op;
        logic [`EX_DATA_W-1:0]     pc;
        logic [`EX_DATA_W-1:0]     oprand1;
        logic [`EX_DATA_W-1:0]     oprand2;
        logic [`EX_DATA_W-1:0]     imm;
        logic [`EX_REG_ADDR_W-1:0] waddr;
        logic                      wreg;
    } ex_issue_t;

    typedef struct packed {
        logic                  ce;
        logic                  we;
        ex_size_e              size;
        logic [`EX_SEL_W-1:0]  sel;
        logic [`EX_DATA_W-1:0] addr;
        logic [`EX_DATA_W-1:0] data;
    } dcache_req_t;

    typedef struct packed {
        logic                      valid;
        ex_op_e                    op;
        logic [`EX_DATA_W-1:0]     pc;
        logic [`EX_REG_ADDR_W-1:0] waddr;
        logic                      wreg;
        logic [`EX_DATA_W-1:0]     wdata;
        logic [`EX_DATA_W-1:0]     mem_addr;
        logic                      excp_ale;
    } ex_mem_t;

    typedef struct packed {
        logic                      wreg;
        logic                      data_valid;
        logic [`EX_REG_ADDR_W-1:0] waddr;
        logic [`EX_DATA_W-1:0]     wdata;
    } ex_fwd_t;

    // One slot of the accepted-access index history
    typedef struct packed {
        logic                   valid;
        logic [`EX_INDEX_W-1:0] index;
    } mem_hist_t;

    function automatic logic op_is_load(ex_op_e op);
        return op inside {OP_LD_B, OP_LD_BU, OP_LD_H, OP_LD_HU, OP_LD_W};
    endfunction

    function automatic logic op_is_store(ex_op_e op);
        return op inside {OP_ST_B, OP_ST_H, OP_ST_W};
    endfunction

endpackage

//--- verilog/ex_result_stage.sv
`timescale 1ns/10ps
`include "ex_settings.svh"

module ex_result_stage
    import ex_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  ex_issue_t             issue_i,
    input  logic [`EX_DATA_W-1:0] int_result_i,
    input  logic [`EX_DATA_W-1:0] mem_addr_i,
    input  logic                  excp_ale_i,
    input  logic                  advance_i,
    input  logic                  flush_i,
    input  logic                  clear_i,
    output ex_mem_t               ex_mem_o,
    output ex_fwd_t               fwd_o
);

    logic    is_load;
    logic    is_mem;
    ex_mem_t ex_mem_d;

    assign is_load = op_is_load(issue_i.op);
    assign is_mem  = is_load | op_is_store(issue_i.op);

    ////////////////////////////////////////////////////////////
    // Record assembly
    ////////////////////////////////////////////////////////////

    always_comb begin
        ex_mem_d.valid = issue_i.valid;
        ex_mem_d.op    = issue_i.op;
        ex_mem_d.pc    = issue_i.pc;
        ex_mem_d.waddr = issue_i.waddr;
        ex_mem_d.wreg  = issue_i.valid & issue_i.wreg;

        // Loads get their data in MEM, address only for memory ops
        if (is_mem) begin
            ex_mem_d.wdata    = '0;
            ex_mem_d.mem_addr = mem_addr_i;
            ex_mem_d.excp_ale = excp_ale_i;
        end else begin
            ex_mem_d.wdata    = int_result_i;
            ex_mem_d.mem_addr = '0;
            ex_mem_d.excp_ale = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ex_mem_o <= '0;
        end else if (flush_i | clear_i) begin
            ex_mem_o <= '0;
        end else if (advance_i) begin
            ex_mem_o <= ex_mem_d;
        end
    end

    ////////////////////////////////////////////////////////////
    // Forwarding to dispatch
    ////////////////////////////////////////////////////////////

    assign fwd_o.wreg       = ex_mem_d.wreg;
    assign fwd_o.data_valid = ~is_load;
    assign fwd_o.waddr      = ex_mem_d.waddr;
    assign fwd_o.wdata      = ex_mem_d.wdata;

    assert property (@(posedge clk) disable iff (rst)
        flush_i |=> !ex_mem_o.valid);

endmodule

//--- verilog/ex_settings.svh
`ifndef EX_SETTINGS_SVH
`define EX_SETTINGS_SVH

////////////////////////////////////////////////////////////
// Datapath
////////////////////////////////////////////////////////////

`define EX_DATA_W      32
`define EX_REG_ADDR_W  5

// Byte lanes per data word
`define EX_SEL_W       (`EX_DATA_W / 8)

////////////////////////////////////////////////////////////
// Data cache index field inside the address
////////////////////////////////////////////////////////////

`define EX_INDEX_LSB   4
`define EX_INDEX_MSB   11
`define EX_INDEX_W     (`EX_INDEX_MSB - `EX_INDEX_LSB + 1)

// Jump link value and fall-through step
`define EX_LINK_OFFSET 4

`endif

//--- verilog/ex_stage.sv
`timescale 1ns/10ps
`include "ex_settings.svh"

module ex_stage
    import ex_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  ex_issue_t   issue_i,
    input  logic        advance_i,
    input  logic        flush_i,
    input  logic        clear_i,
    input  logic        dcache_ready_i,
    output logic        advance_ready_o,
    output dcache_req_t dcache_req_o,
    output ex_mem_t     ex_mem_o,
    output ex_fwd_t     fwd_o
);

    logic [`EX_DATA_W-1:0] int_result;
    logic [`EX_DATA_W-1:0] mem_addr;
    logic                  excp_ale;
    logic                  mem_stall;

    assign advance_ready_o = ~mem_stall;

    ex_int_unit u_int_unit (
        .issue_i      (issue_i),
        .int_result_o (int_result)
    );

    ex_mem_req u_mem_req (
        .clk            (clk),
        .rst            (rst),
        .issue_i        (issue_i),
        .advance_i      (advance_i),
        .dcache_ready_i (dcache_ready_i),
        .flush_i        (flush_i),
        .mem_addr_o     (mem_addr),
        .excp_ale_o     (excp_ale),
        .mem_stall_o    (mem_stall),
        .dcache_req_o   (dcache_req_o)
    );

    ex_result_stage u_result_stage (
        .clk          (clk),
        .rst          (rst),
        .issue_i      (issue_i),
        .int_result_i (int_result),
        .mem_addr_i   (mem_addr),
        .excp_ale_i   (excp_ale),
        .advance_i    (advance_i),
        .flush_i      (flush_i),
        .clear_i      (clear_i),
        .ex_mem_o     (ex_mem_o),
        .fwd_o        (fwd_o)
    );

endmodule
